// ==== logic/clock_pkg.sv ====
package clock_pkg;

    ////////////////////////////////////////
    // button vector layout
    ////////////////////////////////////////

    localparam int NUM_BUTTONS = 5;

    localparam int BTN_CENTER = 0;
    localparam int BTN_RIGHT  = 1;
    localparam int BTN_LEFT   = 2;
    localparam int BTN_UP     = 3;
    localparam int BTN_DOWN   = 4;

    // hh:mm on four seven-segment digits
    localparam int NUM_DIGITS = 4;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    typedef logic [3:0] bcd_t;

    typedef enum logic [2:0] {
        MODE_CLOCK          = 3'd0,
        MODE_RING           = 3'd1,
        MODE_ADJ_TIME_HOUR  = 3'd2,
        MODE_ADJ_TIME_MIN   = 3'd3,
        MODE_ADJ_ALARM_HOUR = 3'd4,
        MODE_ADJ_ALARM_MIN  = 3'd5
    } mode_t;

    // single-cycle adjust opcodes toward the time keeper
    typedef enum logic [2:0] {
        CMD_NONE      = 3'd0,
        CMD_HOUR_UP   = 3'd1,
        CMD_HOUR_DOWN = 3'd2,
        CMD_MIN_UP    = 3'd3,
        CMD_MIN_DOWN  = 3'd4
    } cmd_t;

endpackage

// ==== logic/button_edge.sv ====
`timescale 1ns/1ps

module button_edge (
    input  logic                              new_clk2,
    input  logic                              reset,
    input  logic [clock_pkg::NUM_BUTTONS-1:0] buttons,
    output logic [clock_pkg::NUM_BUTTONS-1:0] press
);

    // two-flop synchronizer stages
    logic [clock_pkg::NUM_BUTTONS-1:0] sync_1;
    logic [clock_pkg::NUM_BUTTONS-1:0] sync_2;
    // last synchronized level, for edge detect
    logic [clock_pkg::NUM_BUTTONS-1:0] level_d;

    always_ff @(posedge new_clk2 or posedge reset)
    begin
        if (reset)
        begin
            sync_1  <= '0;
            sync_2  <= '0;
            level_d <= '0;
            press   <= '0;
        end
        else
        begin
            sync_1  <= buttons;
            sync_2  <= sync_1;
            level_d <= sync_2;
            // one pulse per press, however long it is held
            press   <= sync_2 & ~level_d;
        end
    end

endmodule

// ==== logic/mode_control.sv ====
`timescale 1ns/1ps

module mode_control (
    input  logic                              new_clk2,
    input  logic                              reset,
    input  logic [clock_pkg::NUM_BUTTONS-1:0] press,
    input  logic                              alarm_hit,
    output clock_pkg::cmd_t                   cmd,
    output logic                              cmd_alarm,
    output logic                              run,
    output logic                              show_alarm,
    output logic [4:0]                        leds,
    output logic                              alarm_sound
);

    clock_pkg::mode_t mode;
    clock_pkg::mode_t next_mode;
    clock_pkg::cmd_t  next_cmd;
    logic             next_cmd_alarm;
    logic             hour_mode;
    logic             alarm_mode;

    assign hour_mode  = (mode == clock_pkg::MODE_ADJ_TIME_HOUR) ||
                        (mode == clock_pkg::MODE_ADJ_ALARM_HOUR);
    assign alarm_mode = (mode == clock_pkg::MODE_ADJ_ALARM_HOUR) ||
                        (mode == clock_pkg::MODE_ADJ_ALARM_MIN);

    ////////////////////////////////////////
    // next mode and command
    ////////////////////////////////////////

    always_comb
    begin
        next_mode      = mode;
        next_cmd       = clock_pkg::CMD_NONE;
        next_cmd_alarm = cmd_alarm;
        case (mode)
            clock_pkg::MODE_CLOCK:
            begin
                // alarm wins over a press in the same cycle
                if (alarm_hit)
                    next_mode = clock_pkg::MODE_RING;
                else if (press[clock_pkg::BTN_CENTER])
                    next_mode = clock_pkg::MODE_ADJ_TIME_HOUR;
            end
            clock_pkg::MODE_RING:
            begin
                if (|press)
                    next_mode = clock_pkg::MODE_CLOCK;
            end
            clock_pkg::MODE_ADJ_TIME_HOUR,
            clock_pkg::MODE_ADJ_TIME_MIN,
            clock_pkg::MODE_ADJ_ALARM_HOUR,
            clock_pkg::MODE_ADJ_ALARM_MIN:
            begin
                if (press[clock_pkg::BTN_CENTER])
                begin
                    next_mode = clock_pkg::MODE_CLOCK;
                end
                else if (press[clock_pkg::BTN_LEFT])
                begin
                    // forward through the adjust ring
                    case (mode)
                        clock_pkg::MODE_ADJ_TIME_HOUR:  next_mode = clock_pkg::MODE_ADJ_TIME_MIN;
                        clock_pkg::MODE_ADJ_TIME_MIN:   next_mode = clock_pkg::MODE_ADJ_ALARM_HOUR;
                        clock_pkg::MODE_ADJ_ALARM_HOUR: next_mode = clock_pkg::MODE_ADJ_ALARM_MIN;
                        default:                        next_mode = clock_pkg::MODE_ADJ_TIME_HOUR;
                    endcase
                end
                else if (press[clock_pkg::BTN_RIGHT])
                begin
                    case (mode)
                        clock_pkg::MODE_ADJ_TIME_HOUR:  next_mode = clock_pkg::MODE_ADJ_ALARM_MIN;
                        clock_pkg::MODE_ADJ_TIME_MIN:   next_mode = clock_pkg::MODE_ADJ_TIME_HOUR;
                        clock_pkg::MODE_ADJ_ALARM_HOUR: next_mode = clock_pkg::MODE_ADJ_TIME_MIN;
                        default:                        next_mode = clock_pkg::MODE_ADJ_ALARM_HOUR;
                    endcase
                end
                else if (press[clock_pkg::BTN_UP])
                begin
                    next_cmd       = hour_mode ? clock_pkg::CMD_HOUR_UP : clock_pkg::CMD_MIN_UP;
                    next_cmd_alarm = alarm_mode;
                end
                else if (press[clock_pkg::BTN_DOWN])
                begin
                    next_cmd       = hour_mode ? clock_pkg::CMD_HOUR_DOWN : clock_pkg::CMD_MIN_DOWN;
                    next_cmd_alarm = alarm_mode;
                end
            end
            default:
                next_mode = clock_pkg::MODE_CLOCK;
        endcase
    end

    always_ff @(posedge new_clk2 or posedge reset)
    begin
        if (reset)
        begin
            mode      <= clock_pkg::MODE_CLOCK;
            cmd       <= clock_pkg::CMD_NONE;
            cmd_alarm <= 1'b0;
        end
        else
        begin
            mode      <= next_mode;
            cmd       <= next_cmd;
            cmd_alarm <= next_cmd_alarm;
        end
    end

    ////////////////////////////////////////
    // mode outputs
    ////////////////////////////////////////

    assign run         = (mode == clock_pkg::MODE_CLOCK) || (mode == clock_pkg::MODE_RING);
    assign show_alarm  = alarm_mode;
    // steady tone while ringing
    assign alarm_sound = (mode == clock_pkg::MODE_RING);

    always_comb
    begin
        case (mode)
            clock_pkg::MODE_RING:           leds = 5'b00001;
            clock_pkg::MODE_ADJ_TIME_HOUR:  leds = 5'b10001;
            clock_pkg::MODE_ADJ_TIME_MIN:   leds = 5'b01001;
            clock_pkg::MODE_ADJ_ALARM_HOUR: leds = 5'b00101;
            clock_pkg::MODE_ADJ_ALARM_MIN:  leds = 5'b00011;
            default:                        leds = 5'b00000;
        endcase
    end

endmodule

// ==== logic/time_keeper.sv ====
`timescale 1ns/1ps

module time_keeper #(
    parameter int TICKS_PER_SEC = 200
) (
    input  logic            new_clk2,
    input  logic            reset,
    input  logic            run,
    input  clock_pkg::cmd_t cmd,
    input  logic            cmd_alarm,
    output logic            alarm_hit,
    output clock_pkg::bcd_t time_hh_t,
    output clock_pkg::bcd_t time_hh_u,
    output clock_pkg::bcd_t time_mm_t,
    output clock_pkg::bcd_t time_mm_u,
    output clock_pkg::bcd_t alarm_hh_t,
    output clock_pkg::bcd_t alarm_hh_u,
    output clock_pkg::bcd_t alarm_mm_t,
    output clock_pkg::bcd_t alarm_mm_u
);

    localparam int PRE_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICKS_PER_SEC - 1);

    ////////////////////////////////////////
    // bcd step rules, tens and units
    ////////////////////////////////////////

    // 00..59 with wrap both ways
    function automatic logic [7:0] step_minute(input clock_pkg::bcd_t t,
                                               input clock_pkg::bcd_t u,
                                               input logic up);
        clock_pkg::bcd_t nt;
        clock_pkg::bcd_t nu;
        nt = t;
        nu = u;
        if (up)
        begin
            if (u == 4'd9)
            begin
                nu = 4'd0;
                nt = (t == 4'd5) ? 4'd0 : t + 4'd1;
            end
            else
                nu = u + 4'd1;
        end
        else
        begin
            if (u == 4'd0)
            begin
                nu = 4'd9;
                nt = (t == 4'd0) ? 4'd5 : t - 4'd1;
            end
            else
                nu = u - 4'd1;
        end
        return {nt, nu};
    endfunction

    // 00..23 with wrap both ways
    function automatic logic [7:0] step_hour(input clock_pkg::bcd_t t,
                                             input clock_pkg::bcd_t u,
                                             input logic up);
        logic [7:0] res;
        if (up)
        begin
            if (t == 4'd2 && u == 4'd3)
                res = 8'h00;
            else if (u == 4'd9)
                res = {t + 4'd1, 4'd0};
            else
                res = {t, u + 4'd1};
        end
        else
        begin
            if (t == 4'd0 && u == 4'd0)
                res = 8'h23;
            else if (u == 4'd0)
                res = {t - 4'd1, 4'd9};
            else
                res = {t, u - 4'd1};
        end
        return res;
    endfunction

    clock_pkg::bcd_t  ss_t;
    clock_pkg::bcd_t  ss_u;
    logic [PRE_W-1:0] prescale;
    logic             sec_tick;
    logic             rollover;
    logic [7:0]       sec_inc;
    logic [7:0]       min_inc;
    logic [7:0]       hour_inc;
    logic [7:0]       roll_hh;
    logic             alarm_match;
    logic             cmd_up;
    logic             time_cmd;
    logic [7:0]       cmd_hour;
    logic [7:0]       cmd_min;

    assign sec_tick = run && (prescale == PRE_LAST);
    assign sec_inc  = step_minute(ss_t, ss_u, 1'b1);
    assign min_inc  = step_minute(time_mm_t, time_mm_u, 1'b1);
    assign hour_inc = step_hour(time_hh_t, time_hh_u, 1'b1);
    // seconds wrap to 00 on this tick
    assign rollover = sec_tick && (sec_inc == 8'h00);
    assign roll_hh  = (min_inc == 8'h00) ? hour_inc : {time_hh_t, time_hh_u};

    assign alarm_match = (min_inc == {alarm_mm_t, alarm_mm_u}) &&
                         (roll_hh == {alarm_hh_t, alarm_hh_u});

    // command operand comes from the register it targets
    assign cmd_up   = (cmd == clock_pkg::CMD_HOUR_UP) || (cmd == clock_pkg::CMD_MIN_UP);
    assign time_cmd = (cmd != clock_pkg::CMD_NONE) && !cmd_alarm;
    assign cmd_hour = cmd_alarm ? step_hour(alarm_hh_t, alarm_hh_u, cmd_up)
                                : step_hour(time_hh_t, time_hh_u, cmd_up);
    assign cmd_min  = cmd_alarm ? step_minute(alarm_mm_t, alarm_mm_u, cmd_up)
                                : step_minute(time_mm_t, time_mm_u, cmd_up);

    always_ff @(posedge new_clk2 or posedge reset)
    begin
        if (reset)
        begin
            prescale  <= '0;
            ss_t      <= 4'd0;
            ss_u      <= 4'd0;
            {time_hh_t, time_hh_u}   <= 8'h00;
            {time_mm_t, time_mm_u}   <= 8'h00;
            {alarm_hh_t, alarm_hh_u} <= 8'h00;
            {alarm_mm_t, alarm_mm_u} <= 8'h00;
            alarm_hit <= 1'b0;
        end
        else
        begin
            alarm_hit <= rollover && alarm_match;
            if (time_cmd)
            begin
                // any time adjust restarts the minute
                prescale <= '0;
                ss_t     <= 4'd0;
                ss_u     <= 4'd0;
            end
            else if (run)
            begin
                prescale <= sec_tick ? '0 : prescale + 1'b1;
                if (sec_tick)
                begin
                    {ss_t, ss_u} <= sec_inc;
                    if (rollover)
                    begin
                        {time_mm_t, time_mm_u} <= min_inc;
                        {time_hh_t, time_hh_u} <= roll_hh;
                    end
                end
            end
            case (cmd)
                clock_pkg::CMD_HOUR_UP, clock_pkg::CMD_HOUR_DOWN:
                begin
                    if (cmd_alarm)
                        {alarm_hh_t, alarm_hh_u} <= cmd_hour;
                    else
                        {time_hh_t, time_hh_u} <= cmd_hour;
                end
                clock_pkg::CMD_MIN_UP, clock_pkg::CMD_MIN_DOWN:
                begin
                    if (cmd_alarm)
                        {alarm_mm_t, alarm_mm_u} <= cmd_min;
                    else
                        {time_mm_t, time_mm_u} <= cmd_min;
                end
                default:
                begin
                end
            endcase
        end
    end

endmodule

// ==== logic/display_scan.sv ====
`timescale 1ns/1ps

module display_scan #(
    parameter int SCAN_BITS = 10
) (
    input  logic                             new_clk2,
    input  logic                             reset,
    input  logic                             show_alarm,
    input  clock_pkg::bcd_t                  time_hh_t,
    input  clock_pkg::bcd_t                  time_hh_u,
    input  clock_pkg::bcd_t                  time_mm_t,
    input  clock_pkg::bcd_t                  time_mm_u,
    input  clock_pkg::bcd_t                  alarm_hh_t,
    input  clock_pkg::bcd_t                  alarm_hh_u,
    input  clock_pkg::bcd_t                  alarm_mm_t,
    input  clock_pkg::bcd_t                  alarm_mm_u,
    output logic [6:0]                       segments,
    output logic [clock_pkg::NUM_DIGITS-1:0] anodes
);

    localparam int SEL_W = $clog2(clock_pkg::NUM_DIGITS);

    logic [SCAN_BITS-1:0] scan_cnt;
    logic [SEL_W-1:0]     scan_sel;
    logic [SEL_W-1:0]     digit_idx;
    clock_pkg::bcd_t      digit;

    // free-running refresh counter
    always_ff @(posedge new_clk2 or posedge reset)
    begin
        if (reset)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    // scan starts at the hour tens digit
    assign scan_sel  = scan_cnt[SCAN_BITS-1 -: SEL_W];
    assign digit_idx = SEL_W'(clock_pkg::NUM_DIGITS - 1) - scan_sel;
    assign anodes    = ~(clock_pkg::NUM_DIGITS'(1) << digit_idx);

    always_comb
    begin
        case (digit_idx)
            2'd3:    digit = show_alarm ? alarm_hh_t : time_hh_t;
            2'd2:    digit = show_alarm ? alarm_hh_u : time_hh_u;
            2'd1:    digit = show_alarm ? alarm_mm_t : time_mm_t;
            default: digit = show_alarm ? alarm_mm_u : time_mm_u;
        endcase
    end

    ////////////////////////////////////////
    // segment decode, active low, gfedcba
    ////////////////////////////////////////

    always_comb
    begin
        case (digit)
            4'd0:    segments = 7'b1000000;
            4'd1:    segments = 7'b1111001;
            4'd2:    segments = 7'b0100100;
            4'd3:    segments = 7'b0110000;
            4'd4:    segments = 7'b0011001;
            4'd5:    segments = 7'b0010010;
            4'd6:    segments = 7'b0000010;
            4'd7:    segments = 7'b1111000;
            4'd8:    segments = 7'b0000000;
            4'd9:    segments = 7'b0010000;
            default: segments = 7'b1111111;
        endcase
    end

endmodule

// ==== logic/alarm_clock_top.sv ====
`timescale 1ns/1ps

module alarm_clock_top #(
    parameter int TICKS_PER_SEC = 200,
    parameter int SCAN_BITS     = 10
) (
    input  logic                              new_clk2,
    input  logic                              reset,
    input  logic [clock_pkg::NUM_BUTTONS-1:0] buttons,
    output logic [6:0]                        segments,
    output logic [clock_pkg::NUM_DIGITS-1:0]  anodes,
    output logic                              alarm_sound,
    output logic [4:0]                        leds
);

    logic [clock_pkg::NUM_BUTTONS-1:0] press;
    clock_pkg::cmd_t                   cmd;
    logic                              cmd_alarm;
    logic                              run;
    logic                              show_alarm;
    logic                              alarm_hit;

    // digits for the display
    clock_pkg::bcd_t time_hh_t;
    clock_pkg::bcd_t time_hh_u;
    clock_pkg::bcd_t time_mm_t;
    clock_pkg::bcd_t time_mm_u;
    clock_pkg::bcd_t alarm_hh_t;
    clock_pkg::bcd_t alarm_hh_u;
    clock_pkg::bcd_t alarm_mm_t;
    clock_pkg::bcd_t alarm_mm_u;

    button_edge u_button_edge (
        .new_clk2 (new_clk2),
        .reset    (reset),
        .buttons  (buttons),
        .press    (press)
    );

    mode_control u_mode_control (
        .new_clk2    (new_clk2),
        .reset       (reset),
        .press       (press),
        .alarm_hit   (alarm_hit),
        .cmd         (cmd),
        .cmd_alarm   (cmd_alarm),
        .run         (run),
        .show_alarm  (show_alarm),
        .leds        (leds),
        .alarm_sound (alarm_sound)
    );

    time_keeper #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) u_time_keeper (
        .new_clk2   (new_clk2),
        .reset      (reset),
        .run        (run),
        .cmd        (cmd),
        .cmd_alarm  (cmd_alarm),
        .alarm_hit  (alarm_hit),
        .time_hh_t  (time_hh_t),
        .time_hh_u  (time_hh_u),
        .time_mm_t  (time_mm_t),
        .time_mm_u  (time_mm_u),
        .alarm_hh_t (alarm_hh_t),
        .alarm_hh_u (alarm_hh_u),
        .alarm_mm_t (alarm_mm_t),
        .alarm_mm_u (alarm_mm_u)
    );

    display_scan #(
        .SCAN_BITS (SCAN_BITS)
    ) u_display_scan (
        .new_clk2   (new_clk2),
        .reset      (reset),
        .show_alarm (show_alarm),
        .time_hh_t  (time_hh_t),
        .time_hh_u  (time_hh_u),
        .time_mm_t  (time_mm_t),
        .time_mm_u  (time_mm_u),
        .alarm_hh_t (alarm_hh_t),
        .alarm_hh_u (alarm_hh_u),
        .alarm_mm_t (alarm_mm_t),
        .alarm_mm_u (alarm_mm_u),
        .segments   (segments),
        .anodes     (anodes)
    );

endmodule

// ==== test/alarm_clock_assert.sv ====
`timescale 1ns/1ps

module alarm_clock_assert (
    input logic            new_clk2,
    input logic            reset,
    input logic [3:0]      anodes,
    input logic [4:0]      leds,
    input logic            alarm_sound,
    input logic            alarm_hit,
    input logic            run,
    input clock_pkg::cmd_t cmd
);

    anodes_one_hot_low: assert property (@(posedge new_clk2) disable iff (reset)
        $onehot(~anodes))
        else $error("anodes are not one-hot-low");

    sound_only_ring_led: assert property (@(posedge new_clk2) disable iff (reset)
        alarm_sound |-> (leds == 5'b00001))
        else $error("alarm_sound high with leds other than bit 0");

    hit_single_cycle: assert property (@(posedge new_clk2) disable iff (reset)
        alarm_hit |=> !alarm_hit)
        else $error("alarm_hit longer than one cycle");

    // clock mode is running and not ringing
    no_cmd_in_clock: assert property (@(posedge new_clk2) disable iff (reset)
        (run && !alarm_sound) |-> (cmd == clock_pkg::CMD_NONE))
        else $error("adjust command issued in clock mode");

endmodule

bind alarm_clock_top alarm_clock_assert u_clock_assert (
    .new_clk2    (new_clk2),
    .reset       (reset),
    .anodes      (anodes),
    .leds        (leds),
    .alarm_sound (alarm_sound),
    .alarm_hit   (alarm_hit),
    .run         (run),
    .cmd         (cmd)
);

// ==== test/alarm_clock_checker.sv ====
`timescale 1ns/1ps

module alarm_clock_checker (
    input  logic        new_clk2,
    input  logic [6:0]  segments,
    input  logic [3:0]  anodes,
    input  logic [4:0]  leds,
    input  logic        alarm_sound,
    input  logic        check_req,
    input  int          row,
    input  logic [4:0]  exp_leds,
    input  logic        exp_sound,
    input  logic [15:0] exp_digits,
    output logic        check_done,
    output int          error_count
);

    localparam int CHECK_TIMEOUT = 300;

    // lit segments gfedcba from the active-low pins
    function automatic clock_pkg::bcd_t segment_digit(input logic [6:0] seg);
        case (~seg)
            7'h3F:   return 4'd0;
            7'h06:   return 4'd1;
            7'h5B:   return 4'd2;
            7'h4F:   return 4'd3;
            7'h66:   return 4'd4;
            7'h6D:   return 4'd5;
            7'h7D:   return 4'd6;
            7'h07:   return 4'd7;
            7'h7F:   return 4'd8;
            7'h6F:   return 4'd9;
            default: return 4'hF;
        endcase
    endfunction

    // index of the single low anode or -1
    function automatic int anode_index(input logic [3:0] an);
        case (an)
            4'b1110: return 0;
            4'b1101: return 1;
            4'b1011: return 2;
            4'b0111: return 3;
            default: return -1;
        endcase
    endfunction

    task automatic compare_until_match();
        clock_pkg::bcd_t shown [4];
        clock_pkg::bcd_t digit;
        logic [3:0]      seen;
        logic            matched;
        int              pos;
        int              cycles;
        string           got;
        seen    = '0;
        matched = 1'b0;
        cycles  = 0;
        for (int i = 0; i < 4; i++)
            shown[i] = 4'hF;
        while (!matched && cycles < CHECK_TIMEOUT)
        begin
            pos   = anode_index(anodes);
            digit = segment_digit(segments);
            if (pos >= 0)
                shown[pos] = digit;
            if (pos >= 0 && digit == exp_digits[pos*4 +: 4] && leds == exp_leds &&
                alarm_sound == exp_sound)
                seen[pos] = 1'b1;
            else
                seen = '0;
            if (seen == 4'b1111)
                matched = 1'b1;
            else
            begin
                @(negedge new_clk2);
                cycles++;
            end
        end
        if (!matched)
        begin
            error_count++;
            got = $sformatf("%0h%0h:%0h%0h leds %b sound %b",
                            shown[3], shown[2], shown[1], shown[0], leds, alarm_sound);
            $display("FAIL at %0t: row %0d shows %s, expected %h leds %b sound %b",
                     $time, row, got, exp_digits, exp_leds, exp_sound);
        end
    endtask

    // sample outputs at the falling edge where they are stable
    initial
    begin
        $timeformat(-9, 0, " ns", 0);
        check_done  = 1'b0;
        error_count = 0;
        forever
        begin
            @(negedge new_clk2);
            if (check_req && !check_done)
            begin
                compare_until_match();
                check_done = 1'b1;
            end
            else if (!check_req)
                check_done = 1'b0;
        end
    end

endmodule

// ==== test/alarm_clock_tb.sv ====
`timescale 1ns/1ps

module alarm_clock_tb;

    localparam int TICKS_PER_SEC = 2;
    localparam int SCAN_BITS     = 2;
    localparam int MAX_ROWS      = 24;
    // row that only waits, no button pressed
    localparam int NO_BUTTON     = 7;
    localparam int IDLE_CYCLES   = 4;
    localparam int DONE_TIMEOUT  = 400;

    logic        new_clk2;
    logic        reset;
    logic [4:0]  buttons;
    logic [6:0]  segments;
    logic [3:0]  anodes;
    logic        alarm_sound;
    logic [4:0]  leds;

    // checker handshake and expected values
    logic        check_req;
    logic        check_done;
    int          row_idx;
    logic [4:0]  exp_leds;
    logic        exp_sound;
    logic [15:0] exp_digits;
    int          value_errors;
    int          timeout_errors;
    logic        timed_out;
    int          seed;

    // stimulus table, digits as hhmm in bcd
    int          row_button [MAX_ROWS];
    logic [4:0]  row_leds   [MAX_ROWS];
    logic        row_sound  [MAX_ROWS];
    logic [15:0] row_digits [MAX_ROWS];
    int          num_rows;

    alarm_clock_top #(
        .TICKS_PER_SEC (TICKS_PER_SEC),
        .SCAN_BITS     (SCAN_BITS)
    ) UUT (
        .new_clk2    (new_clk2),
        .reset       (reset),
        .buttons     (buttons),
        .segments    (segments),
        .anodes      (anodes),
        .alarm_sound (alarm_sound),
        .leds        (leds)
    );

    alarm_clock_checker u_checker (
        .new_clk2    (new_clk2),
        .segments    (segments),
        .anodes      (anodes),
        .leds        (leds),
        .alarm_sound (alarm_sound),
        .check_req   (check_req),
        .row         (row_idx),
        .exp_leds    (exp_leds),
        .exp_sound   (exp_sound),
        .exp_digits  (exp_digits),
        .check_done  (check_done),
        .error_count (value_errors)
    );

    initial
    begin
        new_clk2 = 1'b0;
        forever
        begin
            #20;
            new_clk2 = ~new_clk2;
        end
    end

    ////////////////////////////////////////
    // table and driver tasks
    ////////////////////////////////////////

    task automatic add_row(input int btn, input logic [4:0] l, input logic s,
                           input logic [15:0] d);
        row_button[num_rows] = btn;
        row_leds[num_rows]   = l;
        row_sound[num_rows]  = s;
        row_digits[num_rows] = d;
        num_rows++;
    endtask

    task automatic load_table();
        num_rows = 0;
        add_row(NO_BUTTON,                5'b00000, 1'b0, 16'h0000);
        // time adjust, hours then minutes
        add_row(clock_pkg::BTN_CENTER,    5'b10001, 1'b0, 16'h0000);
        add_row(clock_pkg::BTN_DOWN,      5'b10001, 1'b0, 16'h2300);
        add_row(clock_pkg::BTN_LEFT,      5'b01001, 1'b0, 16'h2300);
        add_row(clock_pkg::BTN_DOWN,      5'b01001, 1'b0, 16'h2359);
        // alarm hour, display switches to the alarm
        add_row(clock_pkg::BTN_LEFT,      5'b00101, 1'b0, 16'h0000);
        add_row(clock_pkg::BTN_UP,        5'b00101, 1'b0, 16'h0100);
        add_row(clock_pkg::BTN_DOWN,      5'b00101, 1'b0, 16'h0000);
        add_row(clock_pkg::BTN_RIGHT,     5'b01001, 1'b0, 16'h2359);
        add_row(clock_pkg::BTN_RIGHT,     5'b10001, 1'b0, 16'h2359);
        // backward wrap into alarm minute
        add_row(clock_pkg::BTN_RIGHT,     5'b00011, 1'b0, 16'h0000);
        add_row(clock_pkg::BTN_UP,        5'b00011, 1'b0, 16'h0001);
        add_row(clock_pkg::BTN_UP,        5'b00011, 1'b0, 16'h0002);
        add_row(clock_pkg::BTN_CENTER,    5'b00000, 1'b0, 16'h2359);
        // free running, rollover then alarm at 00:02
        add_row(NO_BUTTON,                5'b00000, 1'b0, 16'h0000);
        add_row(NO_BUTTON,                5'b00000, 1'b0, 16'h0001);
        add_row(NO_BUTTON,                5'b00001, 1'b1, 16'h0002);
        add_row(clock_pkg::BTN_UP,        5'b00000, 1'b0, 16'h0002);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge new_clk2);
        #5;
    endtask

    task automatic press_button(input int idx);
        int hold;
        hold = $random(seed) & 3;
        hold = hold + 4;
        buttons[idx] = 1'b1;
        idle_cycles(hold);
        buttons[idx] = 1'b0;
    endtask

    task automatic run_check(input int r);
        int waited;
        row_idx    = r;
        exp_leds   = row_leds[r];
        exp_sound  = row_sound[r];
        exp_digits = row_digits[r];
        check_req  = 1'b1;
        waited     = 0;
        while (!check_done && waited < DONE_TIMEOUT)
        begin
            @(posedge new_clk2);
            waited++;
        end
        #5;
        check_req = 1'b0;
        if (!check_done)
        begin
            timeout_errors++;
            timed_out = 1'b1;
            $display("checker gave no answer for row %0d in %0d cycles", r, DONE_TIMEOUT);
        end
        else
        begin
            // handshake back to idle
            waited = 0;
            while (check_done && waited < DONE_TIMEOUT)
            begin
                @(posedge new_clk2);
                waited++;
            end
            #5;
            if (check_done)
            begin
                timeout_errors++;
                timed_out = 1'b1;
                $display("checker kept its done flag high after row %0d", r);
            end
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial
    begin
        seed           = 27;
        reset          = 1'b1;
        buttons        = '0;
        check_req      = 1'b0;
        row_idx        = 0;
        exp_leds       = '0;
        exp_sound      = 1'b0;
        exp_digits     = '0;
        timeout_errors = 0;
        timed_out      = 1'b0;
        load_table();
        idle_cycles(2);
        reset = 1'b0;
        for (int r = 0; r < num_rows && !timed_out; r++)
        begin
            if (row_button[r] != NO_BUTTON)
                press_button(row_button[r]);
            idle_cycles(IDLE_CYCLES);
            run_check(r);
        end
        $display("errors: value %0d, timeout %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
logic/clock_pkg.sv
logic/button_edge.sv
logic/mode_control.sv
logic/time_keeper.sv
logic/display_scan.sv
logic/alarm_clock_top.sv
test/alarm_clock_assert.sv
test/alarm_clock_checker.sv
test/alarm_clock_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= alarm_clock_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation FAILED
PASS_MSG  ?= Simulation PASSED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
